// ==== sim.f ====
rtl/card_pkg.sv
rtl/card_geometry.sv
rtl/video_delay.sv
rtl/card_pixel_mixer.sv
rtl/card_overlay.sv
verification/card_overlay_chk.sv
verification/card_overlay_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the card overlay testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=card_overlay_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module card_overlay_tb \
    -f sim.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

// ==== verification/card_overlay_tb.sv ====
// Scans a 120x140 frame with the card at the default position; image memory answers in one cycle
module card_overlay_tb;
    import card_pkg::*;

    // ------------------------------
    // Frame timing and card placement
    // ------------------------------
    localparam int H_TOTAL      = 120;
    localparam int V_TOTAL      = 140;
    localparam int H_ACTIVE     = 100;
    localparam int V_ACTIVE     = 120;
    localparam int HS_START     = 104;
    localparam int HS_END       = 112;
    localparam int VS_START     = 124;
    localparam int VS_END       = 128;
    localparam int CARD_XPOS    = 20;
    localparam int CARD_YPOS    = 30;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_LIMIT  = 16;

    typedef struct packed {
        int                     due;
        logic [3:0]             rank;
        logic [1:0]             suit;
        logic                   rst_phase;
        logic [COUNT_W-1:0]     hc;
        logic [COUNT_W-1:0]     vc;
        logic                   hs;
        logic                   vs;
        logic                   hb;
        logic                   vb;
        rgb_t                   rgb;
        logic [SYM_ADDR_W-1:0]  addr;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [COUNT_W-1:0]     hcount_in;
    logic [COUNT_W-1:0]     vcount_in;
    logic                   hsync_in;
    logic                   vsync_in;
    logic                   hblnk_in;
    logic                   vblnk_in;
    rgb_t                   rgb_in;
    rank_e                  card_rank;
    suit_e                  card_suit;
    rgb_t                   rgb_pixel = '0;
    logic [SYM_ADDR_W-1:0]  pixel_addr;
    logic [COUNT_W-1:0]     hcount_out;
    logic [COUNT_W-1:0]     vcount_out;
    logic                   hsync_out;
    logic                   vsync_out;
    logic                   hblnk_out;
    logic                   vblnk_out;
    rgb_t                   rgb_out;

    expect_t                out_q[$];
    expect_t                addr_q[$];
    int                     cyc = 0;
    logic [15:0]            lfsr = 16'd18;

    always #5 clk = ~clk;

    card_overlay u_card_overlay (
        .clk        (clk),
        .rst        (rst),
        .hcount_in  (hcount_in),
        .vcount_in  (vcount_in),
        .hsync_in   (hsync_in),
        .vsync_in   (vsync_in),
        .hblnk_in   (hblnk_in),
        .vblnk_in   (vblnk_in),
        .rgb_in     (rgb_in),
        .card_rank  (card_rank),
        .card_suit  (card_suit),
        .rgb_pixel  (rgb_pixel),
        .pixel_addr (pixel_addr),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb_out    (rgb_out)
    );

    // Image memory model with one cycle of read latency
    always @(posedge clk) begin
        rgb_pixel <= {1'b0, pixel_addr} ^ 12'ha5a;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic rgb_t mem_color(input int addr);
        return 12'(addr) ^ 12'ha5a;
    endfunction

    function automatic bit in_box(input int dx, input int dy, input int x0, input int y0,
                                  input int w, input int h);
        return (dx >= x0) && (dx < x0 + w) && (dy >= y0) && (dy < y0 + h);
    endfunction

    function automatic bit card_hit(input int hc, input int vc, input int rank);
        int dx;
        int dy;
        dx = hc - CARD_XPOS;
        dy = vc - CARD_YPOS;
        return (rank >= 1) && (rank <= 13) && (dx >= 0) && (dx <= CARD_W) && (dy >= 0)
            && (dy <= CARD_H);
    endfunction

    function automatic int ref_addr(input int hc, input int vc, input int rank);
        int dx;
        int dy;
        dx = hc - CARD_XPOS;
        dy = vc - CARD_YPOS;
        if (card_hit(hc, vc, rank) && in_box(dx, dy, SYM_X_OFF, SYM_Y_OFF, SYM_W, SYM_H)) begin
            return (dy - SYM_Y_OFF) * SYM_W + (dx - SYM_X_OFF);
        end
        return 0;
    endfunction

    function automatic rgb_t ref_pixel(input int hc, input int vc, input int rank,
                                       input int suit, input rgb_t bg);
        int                         dx;
        int                         dy;
        int                         bit_idx;
        logic [GLYPH_W*GLYPH_H-1:0] glyph;
        dx = hc - CARD_XPOS;
        dy = vc - CARD_YPOS;
        if (!card_hit(hc, vc, rank)) begin
            return bg;
        end
        if (in_box(dx, dy, SYM_X_OFF, SYM_Y_OFF, SYM_W, SYM_H)) begin
            return mem_color(ref_addr(hc, vc, rank));
        end
        if (in_box(dx, dy, GLYPH_X_OFF, GLYPH_Y_OFF, GLYPH_W, GLYPH_H)) begin
            glyph   = RANK_GLYPH[4'(rank)];
            bit_idx = (dy - GLYPH_Y_OFF) * GLYPH_W + (dx - GLYPH_X_OFF);
            if (!glyph[6'(bit_idx)]) begin
                return COLOR_WHITE;
            end
            // Hearts and diamonds are red
            if ((suit == int'(HEARTS)) || (suit == int'(DIAMONDS))) begin
                return COLOR_RED;
            end
            return COLOR_BLACK;
        end
        if ((dx == 0) || (dx == CARD_W) || (dy == 0) || (dy == CARD_H)) begin
            return COLOR_BLACK;
        end
        return COLOR_WHITE;
    endfunction

    function automatic string test_label(input expect_t e);
        if (e.rst_phase) begin
            return "reset";
        end
        if ((e.rank == 4'd0) || (e.rank > 4'd13)) begin
            return $sformatf("passthrough rank %0d", e.rank);
        end
        return $sformatf("rank %0d suit %0d", e.rank, e.suit);
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test, field, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic drive_pixel(input int hc, input int vc, input int rank, input int suit,
                               input logic in_reset);
        rgb_t    bg;
        expect_t e;
        logic    hs;
        logic    vs;
        logic    hb;
        logic    vb;
        int      b;
        for (b = 0; b < 12; b++) begin
            lfsr  = lfsr_next(lfsr);
            bg[b] = lfsr[0];
        end
        hs = (hc >= HS_START) && (hc < HS_END);
        vs = (vc >= VS_START) && (vc < VS_END);
        hb = (hc >= H_ACTIVE);
        vb = (vc >= V_ACTIVE);
        @(posedge clk);
        rst       <= in_reset;
        hcount_in <= COUNT_W'(hc);
        vcount_in <= COUNT_W'(vc);
        hsync_in  <= hs;
        vsync_in  <= vs;
        hblnk_in  <= hb;
        vblnk_in  <= vb;
        rgb_in    <= bg;
        card_rank <= rank_e'(4'(rank));
        card_suit <= suit_e'(2'(suit));
        e           = '0;
        e.due       = cyc + 4;
        e.rank      = 4'(rank);
        e.suit      = 2'(suit);
        e.rst_phase = in_reset;
        // Everything reads zero while reset holds the pipeline
        if (!in_reset) begin
            e.hc   = COUNT_W'(hc);
            e.vc   = COUNT_W'(vc);
            e.hs   = hs;
            e.vs   = vs;
            e.hb   = hb;
            e.vb   = vb;
            e.rgb  = ref_pixel(hc, vc, rank, suit, bg);
            e.addr = SYM_ADDR_W'(ref_addr(hc, vc, rank));
        end
        out_q.push_back(e);
        e.due = cyc + 2;
        addr_q.push_back(e);
    endtask

    task automatic run_frame(input int rank, input int suit);
        int hc;
        int vc;
        for (vc = 0; vc < V_TOTAL; vc++) begin
            for (hc = 0; hc < H_TOTAL; hc++) begin
                drive_pixel(hc, vc, rank, suit, 1'b0);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((out_q.size() > 0) || (addr_q.size() > 0)) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("Output pipeline did not drain within %0d cycles", DRAIN_LIMIT);
                $display("TEST FAILED");
                $fatal(1, "drain timeout");
            end
        end
    endtask

    // ------------------------------
    // Comparison at the falling edge where outputs are stable
    // ------------------------------
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        string   label;
        cyc = cyc + 1;
        if ((addr_q.size() > 0) && (addr_q[0].due == cyc)) begin
            e = addr_q.pop_front();
            check_value(test_label(e), "pixel_addr", 32'(e.addr), 32'(pixel_addr));
        end
        if ((out_q.size() > 0) && (out_q[0].due == cyc)) begin
            e     = out_q.pop_front();
            label = test_label(e);
            check_value(label, "hcount_out", 32'(e.hc), 32'(hcount_out));
            check_value(label, "vcount_out", 32'(e.vc), 32'(vcount_out));
            check_value(label, "hsync_out", 32'(e.hs), 32'(hsync_out));
            check_value(label, "vsync_out", 32'(e.vs), 32'(vsync_out));
            check_value(label, "hblnk_out", 32'(e.hb), 32'(hblnk_out));
            check_value(label, "vblnk_out", 32'(e.vb), 32'(vblnk_out));
            check_value(label, "rgb_out", 32'(e.rgb), 32'(rgb_out));
        end
    end

    initial begin : main_sequence
        int i;
        int r;
        int s;
        rst       <= 1'b1;
        hcount_in <= '0;
        vcount_in <= '0;
        hsync_in  <= 1'b0;
        vsync_in  <= 1'b0;
        hblnk_in  <= 1'b0;
        vblnk_in  <= 1'b0;
        rgb_in    <= '0;
        card_rank <= RANK_NONE;
        card_suit <= SPADES;
        // Card pixels and a live stream during reset
        for (i = 0; i < RESET_CYCLES; i++) begin
            drive_pixel(CARD_XPOS + i, CARD_YPOS, 1, 2, 1'b1);
        end
        run_frame(0, 0);
        for (r = 1; r <= 13; r++) begin
            for (s = 0; s < 4; s++) begin
                run_frame(r, s);
            end
        end
        // Unused code behaves as an empty slot
        run_frame(15, 2);
        wait_drain();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verification/card_overlay_chk.sv ====
// Sync checks hold only after three clean cycles following reset; image window is 40x40
module card_overlay_chk (
    input logic                             clk,
    input logic                             rst,
    input logic                             hsync_in,
    input logic                             vsync_in,
    input logic                             hsync_out,
    input logic                             vsync_out,
    input logic [card_pkg::SYM_ADDR_W-1:0]  pixel_addr,
    input card_pkg::rgb_t                   rgb_out
);
    import card_pkg::*;

    localparam int LATENCY = 3;

    // Counts clean cycles so the delay line holds real data
    logic [1:0] live_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            live_cnt <= '0;
        end else if (live_cnt != 2'd3) begin
            live_cnt <= live_cnt + 2'd1;
        end
    end

    // ------------------------------
    // Stream alignment
    // ------------------------------
    a_hsync_delay: assert property (@(posedge clk) disable iff (rst)
        (live_cnt == 2'd3) |-> (hsync_out == $past(hsync_in, LATENCY)))
        else $error("hsync_out differs from hsync_in three cycles earlier");

    a_vsync_delay: assert property (@(posedge clk) disable iff (rst)
        (live_cnt == 2'd3) |-> (vsync_out == $past(vsync_in, LATENCY)))
        else $error("vsync_out differs from vsync_in three cycles earlier");

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        pixel_addr < SYM_ADDR_W'(SYM_W * SYM_H))
        else $error("pixel_addr beyond the image window");

    a_rgb_after_reset: assert property (@(posedge clk) $fell(rst) |=> (rgb_out == '0))
        else $error("rgb_out not zero in the cycle after reset");

endmodule

bind card_overlay card_overlay_chk u_card_overlay_chk (
    .clk        (clk),
    .rst        (rst),
    .hsync_in   (hsync_in),
    .vsync_in   (vsync_in),
    .hsync_out  (hsync_out),
    .vsync_out  (vsync_out),
    .pixel_addr (pixel_addr),
    .rgb_out    (rgb_out)
);

// ==== rtl/card_overlay.sv ====
// Three-cycle overlay; the image memory must answer pixel_addr exactly one cycle later
module card_overlay #(
    parameter int CARD_XPOS = 20,
    parameter int CARD_YPOS = 30
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [card_pkg::COUNT_W-1:0]        hcount_in,
    input  logic [card_pkg::COUNT_W-1:0]        vcount_in,
    input  logic                                hsync_in,
    input  logic                                vsync_in,
    input  logic                                hblnk_in,
    input  logic                                vblnk_in,
    input  card_pkg::rgb_t                      rgb_in,
    input  card_pkg::rank_e                     card_rank,
    input  card_pkg::suit_e                     card_suit,
    input  card_pkg::rgb_t                      rgb_pixel,
    output logic [card_pkg::SYM_ADDR_W-1:0]     pixel_addr,
    output logic [card_pkg::COUNT_W-1:0]        hcount_out,
    output logic [card_pkg::COUNT_W-1:0]        vcount_out,
    output logic                                hsync_out,
    output logic                                vsync_out,
    output logic                                hblnk_out,
    output logic                                vblnk_out,
    output card_pkg::rgb_t                      rgb_out
);
    import card_pkg::*;

    region_e            region;
    logic               glyph_on;
    logic [COUNT_W-1:0] hcount_dly;
    logic [COUNT_W-1:0] vcount_dly;
    logic               hsync_dly;
    logic               vsync_dly;
    logic               hblnk_dly;
    logic               vblnk_dly;
    rgb_t               rgb_dly;

    // ------------------------------
    // Pixel classification
    // ------------------------------
    card_geometry #(
        .CARD_XPOS (CARD_XPOS),
        .CARD_YPOS (CARD_YPOS)
    ) u_card_geometry (
        .clk, .rst, .hcount_in, .vcount_in, .card_rank,
        .region, .glyph_on, .pixel_addr
    );

    video_delay u_video_delay (
        .clk, .rst, .hcount_in, .vcount_in, .hsync_in, .vsync_in, .hblnk_in, .vblnk_in,
        .rgb_in, .hcount_dly, .vcount_dly, .hsync_dly, .vsync_dly, .hblnk_dly, .vblnk_dly,
        .rgb_dly
    );

    // ------------------------------
    // Colour choice and output
    // ------------------------------
    card_pixel_mixer u_card_pixel_mixer (
        .clk, .rst, .hcount_dly, .vcount_dly, .hsync_dly, .vsync_dly, .hblnk_dly, .vblnk_dly,
        .rgb_dly, .region, .glyph_on, .card_suit, .rgb_pixel,
        .hcount_out, .vcount_out, .hsync_out, .vsync_out, .hblnk_out, .vblnk_out, .rgb_out
    );

endmodule

// ==== rtl/card_pixel_mixer.sv ====
// Expects region and glyph_on one cycle behind the delayed stream; card_suit held per frame
module card_pixel_mixer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [card_pkg::COUNT_W-1:0]    hcount_dly,
    input  logic [card_pkg::COUNT_W-1:0]    vcount_dly,
    input  logic                            hsync_dly,
    input  logic                            vsync_dly,
    input  logic                            hblnk_dly,
    input  logic                            vblnk_dly,
    input  card_pkg::rgb_t                  rgb_dly,
    input  card_pkg::region_e               region,
    input  logic                            glyph_on,
    input  card_pkg::suit_e                 card_suit,
    input  card_pkg::rgb_t                  rgb_pixel,
    output logic [card_pkg::COUNT_W-1:0]    hcount_out,
    output logic [card_pkg::COUNT_W-1:0]    vcount_out,
    output logic                            hsync_out,
    output logic                            vsync_out,
    output logic                            hblnk_out,
    output logic                            vblnk_out,
    output card_pkg::rgb_t                  rgb_out
);
    import card_pkg::*;

    region_e region_q;
    logic    glyph_q;
    rgb_t    suit_color;
    rgb_t    color_nxt;

    // Stage 2 alignment with the memory answer
    always_ff @(posedge clk) begin
        if (rst) begin
            region_q <= REG_OUTSIDE;
            glyph_q  <= 1'b0;
        end else begin
            region_q <= region;
            glyph_q  <= glyph_on;
        end
    end

    always_comb begin
        // Red suits are hearts and diamonds
        suit_color = ((card_suit == HEARTS) || (card_suit == DIAMONDS)) ? COLOR_RED : COLOR_BLACK;
        case (region_q)
            REG_SYMBOL: color_nxt = rgb_pixel;
            REG_GLYPH:  color_nxt = glyph_q ? suit_color : COLOR_WHITE;
            REG_BORDER: color_nxt = COLOR_BLACK;
            REG_FACE:   color_nxt = COLOR_WHITE;
            default:    color_nxt = rgb_dly;
        endcase
    end

    // ------------------------------
    // Output register, stage 3
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_dly;
            vcount_out <= vcount_dly;
            hsync_out  <= hsync_dly;
            vsync_out  <= vsync_dly;
            hblnk_out  <= hblnk_dly;
            vblnk_out  <= vblnk_dly;
            rgb_out    <= color_nxt;
        end
    end

endmodule

// ==== rtl/video_delay.sv ====
// Fixed two-cycle delay matching a memory with exactly one cycle of read latency
module video_delay (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [card_pkg::COUNT_W-1:0]    hcount_in,
    input  logic [card_pkg::COUNT_W-1:0]    vcount_in,
    input  logic                            hsync_in,
    input  logic                            vsync_in,
    input  logic                            hblnk_in,
    input  logic                            vblnk_in,
    input  card_pkg::rgb_t                  rgb_in,
    output logic [card_pkg::COUNT_W-1:0]    hcount_dly,
    output logic [card_pkg::COUNT_W-1:0]    vcount_dly,
    output logic                            hsync_dly,
    output logic                            vsync_dly,
    output logic                            hblnk_dly,
    output logic                            vblnk_dly,
    output card_pkg::rgb_t                  rgb_dly
);
    import card_pkg::*;

    localparam int STAGES = 2;
    localparam int BUS_W  = 2 * COUNT_W + 4 + $bits(rgb_t);

    logic [BUS_W-1:0] bus_in;
    logic [BUS_W-1:0] stage [STAGES];

    // All stream fields move together as one word
    assign bus_in = {hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in, rgb_in};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= bus_in;
            for (int i = 1; i < STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign {hcount_dly, vcount_dly, hsync_dly, vsync_dly, hblnk_dly, vblnk_dly, rgb_dly} =
        stage[STAGES-1];

endmodule

// ==== rtl/card_geometry.sv ====
// Card position must keep the whole card inside the count range; card_rank is held per frame
module card_geometry #(
    parameter int CARD_XPOS = 20,
    parameter int CARD_YPOS = 30
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [card_pkg::COUNT_W-1:0]       hcount_in,
    input  logic [card_pkg::COUNT_W-1:0]       vcount_in,
    input  card_pkg::rank_e                    card_rank,
    output card_pkg::region_e                  region,
    output logic                               glyph_on,
    output logic [card_pkg::SYM_ADDR_W-1:0]    pixel_addr
);
    import card_pkg::*;

    // ------------------------------
    // Bounds in card-relative offsets
    // ------------------------------
    localparam logic [COUNT_W-1:0] X0     = COUNT_W'(CARD_XPOS);
    localparam logic [COUNT_W-1:0] Y0     = COUNT_W'(CARD_YPOS);
    localparam logic [COUNT_W-1:0] X_LAST = COUNT_W'(CARD_W);
    localparam logic [COUNT_W-1:0] Y_LAST = COUNT_W'(CARD_H);
    localparam logic [COUNT_W-1:0] GX0    = COUNT_W'(GLYPH_X_OFF);
    localparam logic [COUNT_W-1:0] GX1    = COUNT_W'(GLYPH_X_OFF + GLYPH_W - 1);
    localparam logic [COUNT_W-1:0] GY0    = COUNT_W'(GLYPH_Y_OFF);
    localparam logic [COUNT_W-1:0] GY1    = COUNT_W'(GLYPH_Y_OFF + GLYPH_H - 1);
    localparam logic [COUNT_W-1:0] SX0    = COUNT_W'(SYM_X_OFF);
    localparam logic [COUNT_W-1:0] SX1    = COUNT_W'(SYM_X_OFF + SYM_W - 1);
    localparam logic [COUNT_W-1:0] SY0    = COUNT_W'(SYM_Y_OFF);
    localparam logic [COUNT_W-1:0] SY1    = COUNT_W'(SYM_Y_OFF + SYM_H - 1);

    // Offsets wrap to large values left of or above the card
    logic [COUNT_W-1:0]             dx;
    logic [COUNT_W-1:0]             dy;
    logic                           rank_valid;
    logic                           in_card;
    logic                           in_sym;
    logic                           in_glyph;
    logic                           on_edge;
    logic [3:0]                     glyph_row;
    logic [2:0]                     glyph_col;
    logic [5:0]                     glyph_idx;
    logic [GLYPH_W*GLYPH_H-1:0]     glyph_map;
    logic [SYM_ADDR_W-1:0]          sym_addr;

    region_e                        region_nxt;
    logic                           glyph_nxt;
    logic [SYM_ADDR_W-1:0]          addr_nxt;

    assign dx = hcount_in - X0;
    assign dy = vcount_in - Y0;

    // Codes 14 and 15 behave like an empty slot
    assign rank_valid = (card_rank != RANK_NONE) && (card_rank <= RANK_KING);

    assign in_card  = (hcount_in >= X0) && (dx <= X_LAST) && (vcount_in >= Y0) && (dy <= Y_LAST);
    assign in_sym   = (dx >= SX0) && (dx <= SX1) && (dy >= SY0) && (dy <= SY1);
    assign in_glyph = (dx >= GX0) && (dx <= GX1) && (dy >= GY0) && (dy <= GY1);
    assign on_edge  = (dx == '0) || (dx == X_LAST) || (dy == '0) || (dy == Y_LAST);

    assign glyph_row = 4'(dy - GY0);
    assign glyph_col = 3'(dx - GX0);
    assign glyph_idx = 6'(glyph_row) * 6'(GLYPH_W) + 6'(glyph_col);
    assign glyph_map = rank_valid ? RANK_GLYPH[card_rank] : '0;

    assign sym_addr = SYM_ADDR_W'(dy - SY0) * SYM_ADDR_W'(SYM_W) + SYM_ADDR_W'(dx - SX0);

    // ------------------------------
    // Classification in priority order
    // ------------------------------
    always_comb begin
        region_nxt = REG_OUTSIDE;
        glyph_nxt  = 1'b0;
        addr_nxt   = '0;
        if (rank_valid && in_card) begin
            if (in_sym) begin
                region_nxt = REG_SYMBOL;
                addr_nxt   = sym_addr;
            end else if (in_glyph) begin
                region_nxt = REG_GLYPH;
                glyph_nxt  = glyph_map[glyph_idx];
            end else if (on_edge) begin
                region_nxt = REG_BORDER;
            end else begin
                region_nxt = REG_FACE;
            end
        end
    end

    // Stage 1 register, the address leaves here for the image memory
    always_ff @(posedge clk) begin
        if (rst) begin
            region     <= REG_OUTSIDE;
            glyph_on   <= 1'b0;
            pixel_addr <= '0;
        end else begin
            region     <= region_nxt;
            glyph_on   <= glyph_nxt;
            pixel_addr <= addr_nxt;
        end
    end

endmodule

// ==== rtl/card_pkg.sv ====
// Shared card constants; rank codes above KING draw nothing and the glyph art is row 0 first
package card_pkg;

    // ------------------------------
    // Stream widths and colours
    // ------------------------------
    localparam int COUNT_W    = 11;
    localparam int SYM_ADDR_W = 11;

    typedef logic [11:0] rgb_t;

    localparam rgb_t COLOR_BLACK = 12'h000;
    localparam rgb_t COLOR_WHITE = 12'hfff;
    localparam rgb_t COLOR_RED   = 12'hf00;

    // ------------------------------
    // Card layout
    // ------------------------------
    // Extents are inclusive, so the card is CARD_W + 1 pixels wide
    localparam int CARD_W = 56;
    localparam int CARD_H = 80;

    localparam int GLYPH_X_OFF = 5;
    localparam int GLYPH_Y_OFF = 5;
    localparam int GLYPH_W     = 7;
    localparam int GLYPH_H     = 9;

    // Suit image window, filled from the external memory
    localparam int SYM_X_OFF = 7;
    localparam int SYM_Y_OFF = 20;
    localparam int SYM_W     = 40;
    localparam int SYM_H     = 40;

    // ------------------------------
    // Enumerations
    // ------------------------------
    typedef enum logic [3:0] {
        RANK_NONE  = 4'd0,
        RANK_ACE   = 4'd1,
        RANK_TWO   = 4'd2,
        RANK_THREE = 4'd3,
        RANK_FOUR  = 4'd4,
        RANK_FIVE  = 4'd5,
        RANK_SIX   = 4'd6,
        RANK_SEVEN = 4'd7,
        RANK_EIGHT = 4'd8,
        RANK_NINE  = 4'd9,
        RANK_TEN   = 4'd10,
        RANK_JACK  = 4'd11,
        RANK_QUEEN = 4'd12,
        RANK_KING  = 4'd13
    } rank_e;

    typedef enum logic [1:0] {
        SPADES,
        CLUBS,
        HEARTS,
        DIAMONDS
    } suit_e;

    typedef enum logic [2:0] {
        REG_OUTSIDE,
        REG_BORDER,
        REG_FACE,
        REG_GLYPH,
        REG_SYMBOL
    } region_e;

    // ------------------------------
    // Rank glyphs
    // ------------------------------
    // Art is given as drawn, leftmost digit is column 0, and gets
    // reversed so that bit (row * GLYPH_W + col) holds each pixel
    function automatic logic [GLYPH_W*GLYPH_H-1:0] glyph_from_art(
        input logic [GLYPH_W*GLYPH_H-1:0] art
    );
        logic [GLYPH_W*GLYPH_H-1:0] bits;
        for (int i = 0; i < GLYPH_W * GLYPH_H; i++) begin
            bits[i] = art[GLYPH_W * GLYPH_H - 1 - i];
        end
        return bits;
    endfunction

    localparam logic [GLYPH_W*GLYPH_H-1:0] RANK_GLYPH [0:13] = '{
        '0,
        glyph_from_art({7'b0011100, 7'b0100010, 7'b1000001,    // A
                        7'b1000001, 7'b1111111, 7'b1000001,
                        7'b1000001, 7'b1000001, 7'b1000001}),
        glyph_from_art({7'b0111110, 7'b1000001, 7'b0000001,    // 2
                        7'b0000010, 7'b0001100, 7'b0010000,
                        7'b0100000, 7'b1000000, 7'b1111111}),
        glyph_from_art({7'b1111110, 7'b0000001, 7'b0000001,    // 3
                        7'b0000001, 7'b0111110, 7'b0000001,
                        7'b0000001, 7'b0000001, 7'b1111110}),
        glyph_from_art({7'b0000110, 7'b0001010, 7'b0010010,    // 4
                        7'b0100010, 7'b1000010, 7'b1111111,
                        7'b0000010, 7'b0000010, 7'b0000010}),
        glyph_from_art({7'b1111111, 7'b1000000, 7'b1000000,    // 5
                        7'b1111110, 7'b0000001, 7'b0000001,
                        7'b0000001, 7'b1000001, 7'b0111110}),
        glyph_from_art({7'b0111110, 7'b1000000, 7'b1000000,    // 6
                        7'b1111110, 7'b1000001, 7'b1000001,
                        7'b1000001, 7'b1000001, 7'b0111110}),
        glyph_from_art({7'b1111111, 7'b0000001, 7'b0000010,    // 7
                        7'b0000100, 7'b0001000, 7'b0010000,
                        7'b0010000, 7'b0010000, 7'b0010000}),
        glyph_from_art({7'b0111110, 7'b1000001, 7'b1000001,    // 8
                        7'b1000001, 7'b0111110, 7'b1000001,
                        7'b1000001, 7'b1000001, 7'b0111110}),
        glyph_from_art({7'b0111110, 7'b1000001, 7'b1000001,    // 9
                        7'b1000001, 7'b0111111, 7'b0000001,
                        7'b0000001, 7'b0000001, 7'b0111110}),
        // Ten squeezes a narrow one and a narrow zero into one box
        glyph_from_art({7'b0100110, 7'b1101001, 7'b0101001,
                        7'b0101001, 7'b0101001, 7'b0101001,
                        7'b0101001, 7'b0101001, 7'b1110110}),
        glyph_from_art({7'b0011111, 7'b0000100, 7'b0000100,    // J
                        7'b0000100, 7'b0000100, 7'b0000100,
                        7'b1000100, 7'b1000100, 7'b0111000}),
        glyph_from_art({7'b0111110, 7'b1000001, 7'b1000001,    // Q
                        7'b1000001, 7'b1000001, 7'b1000001,
                        7'b1000101, 7'b1000010, 7'b0111101}),
        glyph_from_art({7'b1000010, 7'b1000100, 7'b1001000,    // K
                        7'b1010000, 7'b1100000, 7'b1010000,
                        7'b1001000, 7'b1000100, 7'b1000010})
    };

endpackage
